/* list.f */
+incdir+include
logic/tlb_addr_pkg.sv
logic/tlb_op_pkg.sv
logic/tlb_bus_if.sv
logic/tlb_cmd_decode.sv
logic/tlb_entry_array.sv
logic/tlb_xlate.sv
logic/tlb_top.sv
testbench/tb_tlb_top.sv

/* Bender.yml */
package:
  name: tlb

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/tlb_addr_pkg.sv
      - logic/tlb_op_pkg.sv
      - logic/tlb_bus_if.sv
      - logic/tlb_cmd_decode.sv
      - logic/tlb_entry_array.sv
      - logic/tlb_xlate.sv
      - logic/tlb_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_tlb_top.sv

/* testbench/tb_tlb_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_macros.svh"

module tb_tlb_top;
    import tlb_addr_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DLY   = 10;
    localparam int RESET_CYC   = 8;
    localparam int NUM_TESTS   = 5;
    localparam int TEST_CYC    = 200;
    localparam int DRAIN_LIMIT = 20;
    localparam int LOOKUP_LAT  = 2;

    // one expected lookup result
    typedef struct packed {
        logic        miss;
        logic        invalid;
        logic        modified;
        logic        cached;
        paddr_t      paddr;
        logic [31:0] due;
    } result_t;

    logic      aclk;
    logic      rst_n;
    asid_t     cur_asid;
    logic      tlbwi;
    logic      tlbwr;
    logic      tlbp;
    tlb_idx_t  index;
    tlb_idx_t  random_index;
    vpn2_t     hi_vpn2;
    asid_t     hi_asid;
    entry_lo_t lo0;
    entry_lo_t lo1;
    logic      i_req;
    logic      d_req;
    logic      d_store;
    vaddr_t    i_vaddr;
    vaddr_t    d_vaddr;
    logic      i_valid;
    logic      i_miss;
    logic      i_invalid;
    logic      i_cached;
    paddr_t    i_paddr;
    logic      d_valid;
    logic      d_miss;
    logic      d_invalid;
    logic      d_modified;
    logic      d_cached;
    paddr_t    d_paddr;
    logic      probe_done;
    logic      probe_found;
    tlb_idx_t  probe_idx;

    // shadow copy of the entries
    vpn2_t     m_vpn2 [`TLB_ENTRIES];
    asid_t     m_asid [`TLB_ENTRIES];
    entry_lo_t m_lo0  [`TLB_ENTRIES];
    entry_lo_t m_lo1  [`TLB_ENTRIES];
    logic      m_used [`TLB_ENTRIES];

    result_t     exp_i [$];
    result_t     exp_d [$];
    int          errors;
    int          checks;
    logic [31:0] cycle;

    tlb_top UUT (
        .aclk (aclk), .rst_n (rst_n), .cur_asid (cur_asid),
        .tlbwi (tlbwi), .tlbwr (tlbwr), .tlbp (tlbp),
        .index (index), .random_index (random_index),
        .hi_vpn2 (hi_vpn2), .hi_asid (hi_asid), .lo0 (lo0), .lo1 (lo1),
        .i_req (i_req), .d_req (d_req), .d_store (d_store),
        .i_vaddr (i_vaddr), .d_vaddr (d_vaddr),
        .i_valid (i_valid), .i_miss (i_miss), .i_invalid (i_invalid),
        .i_cached (i_cached), .i_paddr (i_paddr),
        .d_valid (d_valid), .d_miss (d_miss), .d_invalid (d_invalid),
        .d_modified (d_modified), .d_cached (d_cached), .d_paddr (d_paddr),
        .probe_done (probe_done), .probe_found (probe_found), .probe_idx (probe_idx)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    // rising edges since time zero
    always @(posedge aclk) begin
        cycle <= cycle + 1;
    end

    // watchdog
    initial begin
        #((NUM_TESTS * TEST_CYC + RESET_CYC) * CLK_PERIOD);
        $display("timeout: the tests did not complete within %0d cycles",
                 NUM_TESTS * TEST_CYC + RESET_CYC);
        $display("Finished with errors");
        $finish;
    end

    function automatic entry_lo_t make_lo(pfn_t pfn, logic [2:0] c, logic d, logic v, logic g);
        return {pfn, c, d, v, g};
    endfunction

    function automatic vaddr_t make_va(vpn2_t vpn2, logic odd, logic [11:0] ofs);
        return {vpn2, odd, ofs};
    endfunction

    function automatic pfn_t rand_pfn();
        logic [31:0] r;
        r = $urandom;
        return r[`PFN_W-1:0];
    endfunction

    function automatic logic [11:0] rand_ofs();
        logic [31:0] r;
        r = $urandom;
        return r[11:0];
    endfunction

    // expected lookup result from the shadow entries
    function automatic result_t predict(vaddr_t va, logic store);
        result_t   r;
        entry_lo_t lo;
        logic      hit;
        hit = 1'b0;
        lo  = '0;
        for (int n = 0; n < `TLB_ENTRIES; n++) begin
            if (m_used[n] && m_vpn2[n] == va[31:13]
                && ((m_lo0[n][0] & m_lo1[n][0]) || m_asid[n] == cur_asid)) begin
                hit = 1'b1;
                // bit 12 selects the odd page
                lo  = va[12] ? m_lo1[n] : m_lo0[n];
            end
        end
        r.miss     = !hit;
        r.invalid  = hit && !lo[1];
        r.modified = hit && store && lo[1] && !lo[2];
        r.cached   = lo[5:3] != 3'd2;
        r.paddr    = {lo[25:6], va[11:0]};
        // sampled on the next edge, valid LOOKUP_LAT edges after that
        r.due      = cycle + 1 + LOOKUP_LAT;
        return r;
    endfunction

    task automatic check_paddr(string what, paddr_t got, paddr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(string what, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_idx(string what, tlb_idx_t got, tlb_idx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_latency(string port, logic [31:0] due);
        checks++;
        if (cycle !== due) begin
            errors++;
            $display("[FAIL] %0t: %s result in cycle %0d, expected cycle %0d",
                     $time, port, cycle, due);
        end
    endtask

    task automatic compare_result(string port, result_t e, logic miss, logic invalid,
                                  logic cached, paddr_t paddr);
        check_latency(port, e.due);
        check_flag({port, "_miss"}, miss, e.miss);
        check_flag({port, "_invalid"}, invalid, e.invalid);
        // address and cache attribute only mean something on a hit
        if (!e.miss) begin
            check_flag({port, "_cached"}, cached, e.cached);
            check_paddr({port, "_paddr"}, paddr, e.paddr);
        end
    endtask

    // results in request order, one pulse per request
    always @(negedge aclk) begin
        if (rst_n && i_valid) begin
            if (exp_i.size() == 0) begin
                errors++;
                $display("instruction port gave a result nobody asked for at %0t", $time);
            end else begin
                compare_result("i", exp_i[0], i_miss, i_invalid, i_cached, i_paddr);
                exp_i.delete(0);
            end
        end
        if (rst_n && d_valid) begin
            if (exp_d.size() == 0) begin
                errors++;
                $display("data port gave a result nobody asked for at %0t", $time);
            end else begin
                compare_result("d", exp_d[0], d_miss, d_invalid, d_cached, d_paddr);
                check_flag("d_modified", d_modified, exp_d[0].modified);
                exp_d.delete(0);
            end
        end
    end

    // next drive point, strobes drop unless driven again
    task automatic advance();
        @(posedge aclk);
        #DRIVE_DLY;
        tlbwi   = 1'b0;
        tlbwr   = 1'b0;
        tlbp    = 1'b0;
        i_req   = 1'b0;
        d_req   = 1'b0;
        d_store = 1'b0;
    endtask

    task automatic request_i(vaddr_t va);
        i_req   = 1'b1;
        i_vaddr = va;
        exp_i.push_back(predict(va, 1'b0));
    endtask

    task automatic request_d(vaddr_t va, logic store);
        d_req   = 1'b1;
        d_vaddr = va;
        d_store = store;
        exp_d.push_back(predict(va, store));
    endtask

    task automatic drain(string what);
        int n;
        n = 0;
        while ((exp_i.size() != 0 || exp_d.size() != 0) && n < DRAIN_LIMIT) begin
            advance();
            n++;
        end
        if (exp_i.size() != 0 || exp_d.size() != 0) begin
            errors++;
            $display("%s: lookup results still missing after %0d cycles", what, DRAIN_LIMIT);
            exp_i.delete();
            exp_d.delete();
        end
        // quiet cycles catch stray valid pulses
        repeat (3) advance();
    endtask

    // the decoy index catches a write to the wrong entry
    task automatic write_entry(logic use_random, tlb_idx_t idx, vpn2_t vpn2, asid_t asid,
                               entry_lo_t l0, entry_lo_t l1);
        advance();
        tlbwi        = !use_random;
        tlbwr        = use_random;
        index        = use_random ? ~idx : idx;
        random_index = use_random ? idx : ~idx;
        hi_vpn2      = vpn2;
        hi_asid      = asid;
        lo0          = l0;
        lo1          = l1;
        m_vpn2[idx]  = vpn2;
        m_asid[idx]  = asid;
        m_lo0[idx]   = l0;
        m_lo1[idx]   = l1;
        m_used[idx]  = 1'b1;
    endtask

    task automatic probe_entry(vpn2_t vpn2, asid_t asid);
        int       n;
        logic     exp_found;
        tlb_idx_t exp_idx;
        exp_found = 1'b0;
        exp_idx   = '0;
        for (int k = 0; k < `TLB_ENTRIES; k++) begin
            if (m_used[k] && m_vpn2[k] == vpn2
                && ((m_lo0[k][0] & m_lo1[k][0]) || m_asid[k] == asid)) begin
                exp_found = 1'b1;
                exp_idx   = k[3:0];
            end
        end
        advance();
        tlbp    = 1'b1;
        hi_vpn2 = vpn2;
        hi_asid = asid;
        advance();
        n = 0;
        while (!probe_done && n < DRAIN_LIMIT) begin
            @(negedge aclk);
            n++;
        end
        if (!probe_done) begin
            errors++;
            $display("probe of vpn2 %h never finished", vpn2);
        end else begin
            check_flag("probe_found", probe_found, exp_found);
            if (exp_found) begin
                check_idx("probe_idx", probe_idx, exp_idx);
            end
        end
    endtask

    task automatic reset_then_write();
        check_flag("i_valid after reset", i_valid, 1'b0);
        check_flag("d_valid after reset", d_valid, 1'b0);
        check_flag("probe_done after reset", probe_done, 1'b0);
        cur_asid = 8'h11;
        advance();
        request_i(make_va(19'h00400, 1'b0, 12'h100));
        request_d(make_va(19'h10008, 1'b1, 12'h020), 1'b0);
        drain("lookups after reset");
        write_entry(1'b0, 4'd3, 19'h00400, 8'h11,
                    make_lo(rand_pfn(), 3'd3, 1'b1, 1'b1, 1'b0),
                    make_lo(rand_pfn(), 3'd3, 1'b1, 1'b1, 1'b0));
        advance();
        request_i(make_va(19'h00400, 1'b0, rand_ofs()));
        drain("lookup after tlbwi");
    endtask

    task automatic page_select();
        write_entry(1'b0, 4'd5, 19'h0a005, 8'h11,
                    make_lo(rand_pfn(), 3'd3, 1'b0, 1'b1, 1'b0),
                    make_lo(rand_pfn(), 3'd3, 1'b1, 1'b1, 1'b0));
        write_entry(1'b0, 4'd6, 19'h0a006, 8'h11,
                    make_lo(rand_pfn(), 3'd3, 1'b1, 1'b0, 1'b0),
                    make_lo(rand_pfn(), 3'd3, 1'b1, 1'b0, 1'b0));
        advance();
        request_d(make_va(19'h0a005, 1'b1, rand_ofs()), 1'b0);
        advance();
        request_d(make_va(19'h0a006, 1'b0, rand_ofs()), 1'b0);
        advance();
        request_d(make_va(19'h0a005, 1'b0, rand_ofs()), 1'b1);
        advance();
        request_d(make_va(19'h0a005, 1'b1, rand_ofs()), 1'b1);
        drain("page select and flags");
    endtask

    task automatic asid_match();
        write_entry(1'b0, 4'd7, 19'h0b007, 8'h22,
                    make_lo(rand_pfn(), 3'd3, 1'b1, 1'b1, 1'b0),
                    make_lo(rand_pfn(), 3'd3, 1'b1, 1'b1, 1'b0));
        write_entry(1'b0, 4'd8, 19'h0b008, 8'h33,
                    make_lo(rand_pfn(), 3'd3, 1'b1, 1'b1, 1'b1),
                    make_lo(rand_pfn(), 3'd3, 1'b1, 1'b1, 1'b1));
        advance();
        cur_asid = 8'h22;
        request_i(make_va(19'h0b007, 1'b0, rand_ofs()));
        request_d(make_va(19'h0b008, 1'b1, rand_ofs()), 1'b0);
        drain("asid 22");
        cur_asid = 8'h44;
        request_i(make_va(19'h0b007, 1'b1, rand_ofs()));
        request_d(make_va(19'h0b008, 1'b0, rand_ofs()), 1'b0);
        advance();
        request_i(make_va(19'h00400, 1'b0, rand_ofs()));
        drain("asid 44");
    endtask

    task automatic random_write_probe();
        cur_asid = 8'h11;
        write_entry(1'b1, 4'd11, 19'h0c00b, 8'h11,
                    make_lo(rand_pfn(), 3'd3, 1'b1, 1'b1, 1'b0),
                    make_lo(rand_pfn(), 3'd3, 1'b1, 1'b1, 1'b0));
        probe_entry(19'h0c00b, 8'h11);
        probe_entry(19'h7ffff, 8'h11);
        advance();
        request_i(make_va(19'h0c00b, 1'b1, rand_ofs()));
        drain("lookup after tlbwr");
    endtask

    function automatic tlb_idx_t pick_entry(int k);
        case (k)
            0: return 4'd3;
            1: return 4'd5;
            2: return 4'd6;
            3: return 4'd7;
            4: return 4'd8;
            5: return 4'd9;
            default: return 4'd11;
        endcase
    endfunction

    task automatic back_to_back();
        logic [31:0] r;
        tlb_idx_t    ei;
        tlb_idx_t    ed;
        write_entry(1'b0, 4'd9, 19'h0d009, 8'h11,
                    make_lo(rand_pfn(), 3'd3, 1'b1, 1'b1, 1'b0),
                    make_lo(rand_pfn(), 3'd2, 1'b1, 1'b1, 1'b0));
        // uncached odd page first
        advance();
        request_i(make_va(19'h0d009, 1'b1, rand_ofs()));
        request_d(make_va(19'h0d009, 1'b1, rand_ofs()), 1'b0);
        repeat (12) begin
            advance();
            r  = $urandom;
            ei = pick_entry(r[2:0] % 7);
            ed = pick_entry(r[5:3] % 7);
            request_i(make_va(m_vpn2[ei], r[8], rand_ofs()));
            request_d(make_va(m_vpn2[ed], r[9], rand_ofs()), r[10]);
        end
        drain("back to back lookups");
    endtask

    initial begin
        void'($urandom(32'h4780));
        errors       = 0;
        checks       = 0;
        cycle        = '0;
        rst_n        = 1'b0;
        cur_asid     = '0;
        tlbwi        = 1'b0;
        tlbwr        = 1'b0;
        tlbp         = 1'b0;
        index        = '0;
        random_index = '0;
        hi_vpn2      = '0;
        hi_asid      = '0;
        lo0          = '0;
        lo1          = '0;
        i_req        = 1'b0;
        d_req        = 1'b0;
        d_store      = 1'b0;
        i_vaddr      = '0;
        d_vaddr      = '0;
        for (int n = 0; n < `TLB_ENTRIES; n++) begin
            m_used[n] = 1'b0;
            m_vpn2[n] = '0;
            m_asid[n] = '0;
            m_lo0[n]  = '0;
            m_lo1[n]  = '0;
        end
        repeat (RESET_CYC) @(posedge aclk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        reset_then_write();
        page_select();
        asid_match();
        random_write_probe();
        back_to_back();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/tlb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_top (
    input  logic                    aclk,
    input  logic                    rst_n,
    input  tlb_addr_pkg::asid_t     cur_asid,
    // maintenance strobes and cp0 fields
    input  logic                    tlbwi,
    input  logic                    tlbwr,
    input  logic                    tlbp,
    input  tlb_addr_pkg::tlb_idx_t  index,
    input  tlb_addr_pkg::tlb_idx_t  random_index,
    input  tlb_addr_pkg::vpn2_t     hi_vpn2,
    input  tlb_addr_pkg::asid_t     hi_asid,
    input  tlb_addr_pkg::entry_lo_t lo0,
    input  tlb_addr_pkg::entry_lo_t lo1,
    // lookup requests
    input  logic                    i_req,
    input  logic                    d_req,
    input  logic                    d_store,
    input  tlb_addr_pkg::vaddr_t    i_vaddr,
    input  tlb_addr_pkg::vaddr_t    d_vaddr,
    // lookup results
    output logic                    i_valid,
    output logic                    i_miss,
    output logic                    i_invalid,
    output logic                    i_cached,
    output tlb_addr_pkg::paddr_t    i_paddr,
    output logic                    d_valid,
    output logic                    d_miss,
    output logic                    d_invalid,
    output logic                    d_modified,
    output logic                    d_cached,
    output tlb_addr_pkg::paddr_t    d_paddr,
    // probe result
    output logic                    probe_done,
    output logic                    probe_found,
    output tlb_addr_pkg::tlb_idx_t  probe_idx
);
    import tlb_addr_pkg::*;

    vpn2_t i_vpn2;
    vpn2_t d_vpn2;

    tlb_wr_if    wr_bus ();
    tlb_match_if mt_bus ();

    tlb_cmd_decode u_cmd_decode (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .tlbwi        (tlbwi),
        .tlbwr        (tlbwr),
        .tlbp         (tlbp),
        .index        (index),
        .random_index (random_index),
        .hi_vpn2      (hi_vpn2),
        .hi_asid      (hi_asid),
        .lo0          (lo0),
        .lo1          (lo1),
        .wr           (wr_bus)
    );

    tlb_entry_array u_entry_array (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .cur_asid (cur_asid),
        .i_vpn2   (i_vpn2),
        .d_vpn2   (d_vpn2),
        .wr       (wr_bus),
        .mt       (mt_bus)
    );

    tlb_xlate u_xlate (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .i_req       (i_req),
        .d_req       (d_req),
        .d_store     (d_store),
        .i_vaddr     (i_vaddr),
        .d_vaddr     (d_vaddr),
        .i_vpn2      (i_vpn2),
        .d_vpn2      (d_vpn2),
        .mt          (mt_bus),
        .i_valid     (i_valid),
        .i_miss      (i_miss),
        .i_invalid   (i_invalid),
        .i_cached    (i_cached),
        .i_paddr     (i_paddr),
        .d_valid     (d_valid),
        .d_miss      (d_miss),
        .d_invalid   (d_invalid),
        .d_modified  (d_modified),
        .d_cached    (d_cached),
        .d_paddr     (d_paddr),
        .probe_done  (probe_done),
        .probe_found (probe_found),
        .probe_idx   (probe_idx)
    );

endmodule

`default_nettype wire

/* logic/tlb_xlate.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_macros.svh"

module tlb_xlate (
    input  logic                   aclk,
    input  logic                   rst_n,
    input  logic                   i_req,
    input  logic                   d_req,
    input  logic                   d_store,
    input  tlb_addr_pkg::vaddr_t   i_vaddr,
    input  tlb_addr_pkg::vaddr_t   d_vaddr,
    output tlb_addr_pkg::vpn2_t    i_vpn2,
    output tlb_addr_pkg::vpn2_t    d_vpn2,
    tlb_match_if.dst               mt,
    output logic                   i_valid,
    output logic                   i_miss,
    output logic                   i_invalid,
    output logic                   i_cached,
    output tlb_addr_pkg::paddr_t   i_paddr,
    output logic                   d_valid,
    output logic                   d_miss,
    output logic                   d_invalid,
    output logic                   d_modified,
    output logic                   d_cached,
    output tlb_addr_pkg::paddr_t   d_paddr,
    output logic                   probe_done,
    output logic                   probe_found,
    output tlb_addr_pkg::tlb_idx_t probe_idx
);
    import tlb_addr_pkg::*;

    // stage 1, sampled requests
    logic                   i_req_q;
    logic                   d_req_q;
    logic                   d_store_q;
    vaddr_t                 i_vaddr_q;
    vaddr_t                 d_vaddr_q;
    // stage 2, matched page
    logic                   i_req_m;
    logic                   d_req_m;
    logic                   d_store_m;
    logic                   i_found_m;
    logic                   d_found_m;
    entry_lo_t              i_lo_m;
    entry_lo_t              d_lo_m;
    logic [`PAGE_OFS_W-1:0] i_ofs_m;
    logic [`PAGE_OFS_W-1:0] d_ofs_m;

    // bit 12 picks the odd page
    function automatic entry_lo_t pick_page(vaddr_t va, entry_lo_t lo0, entry_lo_t lo1);
        return va[`PAGE_OFS_W] ? lo1 : lo0;
    endfunction

    function automatic paddr_t make_paddr(entry_lo_t lo, logic [`PAGE_OFS_W-1:0] ofs);
        pfn_t pfn;
        pfn = lo[`LO_PFN_MSB:`LO_PFN_LSB];
        return {pfn, ofs};
    endfunction

    assign i_vpn2 = i_vaddr_q[`ADDR_W-1:`VPN2_LSB];
    assign d_vpn2 = d_vaddr_q[`ADDR_W-1:`VPN2_LSB];

    // address kept under reset so the array never compares against x
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            i_req_q   <= 1'b0;
            d_req_q   <= 1'b0;
            d_store_q <= 1'b0;
            i_vaddr_q <= '0;
            d_vaddr_q <= '0;
        end else begin
            i_req_q <= i_req;
            d_req_q <= d_req;
            if (i_req) begin
                i_vaddr_q <= i_vaddr;
            end
            if (d_req) begin
                d_vaddr_q <= d_vaddr;
                d_store_q <= d_store;
            end
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            i_req_m <= 1'b0;
            d_req_m <= 1'b0;
        end else begin
            i_req_m <= i_req_q;
            d_req_m <= d_req_q;
        end
    end

    always_ff @(posedge aclk) begin
        i_found_m <= mt.i_found;
        i_lo_m    <= pick_page(i_vaddr_q, mt.i_lo0, mt.i_lo1);
        i_ofs_m   <= i_vaddr_q[`PAGE_OFS_W-1:0];
        d_found_m <= mt.d_found;
        d_lo_m    <= pick_page(d_vaddr_q, mt.d_lo0, mt.d_lo1);
        d_ofs_m   <= d_vaddr_q[`PAGE_OFS_W-1:0];
        d_store_m <= d_store_q;
    end

    // stage 3, results held until the next request on the port
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            i_valid    <= 1'b0;
            i_miss     <= 1'b0;
            i_invalid  <= 1'b0;
            i_cached   <= 1'b0;
            d_valid    <= 1'b0;
            d_miss     <= 1'b0;
            d_invalid  <= 1'b0;
            d_modified <= 1'b0;
            d_cached   <= 1'b0;
        end else begin
            i_valid <= i_req_m;
            d_valid <= d_req_m;
            if (i_req_m) begin
                i_miss    <= !i_found_m;
                i_invalid <= i_found_m && !i_lo_m[`LO_V];
                i_cached  <= i_lo_m[`LO_C_MSB:`LO_C_LSB] != `CACHE_UNCACHED;
            end
            if (d_req_m) begin
                d_miss     <= !d_found_m;
                d_invalid  <= d_found_m && !d_lo_m[`LO_V];
                // store into a clean but valid page
                d_modified <= d_found_m && d_store_m && d_lo_m[`LO_V] && !d_lo_m[`LO_D];
                d_cached   <= d_lo_m[`LO_C_MSB:`LO_C_LSB] != `CACHE_UNCACHED;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (i_req_m) begin
            i_paddr <= make_paddr(i_lo_m, i_ofs_m);
        end
        if (d_req_m) begin
            d_paddr <= make_paddr(d_lo_m, d_ofs_m);
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            probe_done  <= 1'b0;
            probe_found <= 1'b0;
            probe_idx   <= '0;
        end else begin
            probe_done <= mt.probe_strobe;
            if (mt.probe_strobe) begin
                probe_found <= mt.probe_found;
                probe_idx   <= mt.probe_idx;
            end
        end
    end

    assert property (@(posedge aclk) disable iff (!rst_n) !(d_modified && d_miss))
        else $error("tlb_xlate: d_modified raised together with d_miss");

endmodule

`default_nettype wire

/* logic/tlb_entry_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_macros.svh"

module tlb_entry_array (
    input  logic                aclk,
    input  logic                rst_n,
    input  tlb_addr_pkg::asid_t cur_asid,
    input  tlb_addr_pkg::vpn2_t i_vpn2,
    input  tlb_addr_pkg::vpn2_t d_vpn2,
    tlb_wr_if.dst               wr,
    tlb_match_if.src            mt
);
    import tlb_addr_pkg::*;
    import tlb_op_pkg::*;

    // entry storage
    vpn2_t                   ent_vpn2 [`TLB_ENTRIES];
    asid_t                   ent_asid [`TLB_ENTRIES];
    entry_lo_t               ent_lo0  [`TLB_ENTRIES];
    entry_lo_t               ent_lo1  [`TLB_ENTRIES];
    logic [`TLB_ENTRIES-1:0] ent_g;
    // set once an entry has been written since reset
    logic [`TLB_ENTRIES-1:0] ent_used;

    logic [`TLB_ENTRIES-1:0] i_hit;
    logic [`TLB_ENTRIES-1:0] d_hit;
    logic [`TLB_ENTRIES-1:0] p_hit;
    entry_lo_t               i_lo0;
    entry_lo_t               i_lo1;
    entry_lo_t               d_lo0;
    entry_lo_t               d_lo1;
    tlb_idx_t                p_idx;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int n = 0; n < `TLB_ENTRIES; n++) begin
                ent_vpn2[n] <= '0;
                ent_asid[n] <= '0;
                ent_lo0[n]  <= '0;
                ent_lo1[n]  <= '0;
            end
            ent_g    <= '0;
            ent_used <= '0;
        end else if (op_is_write(wr.op)) begin
            ent_vpn2[wr.wr_idx] <= wr.vpn2;
            ent_asid[wr.wr_idx] <= wr.asid;
            ent_lo0[wr.wr_idx]  <= wr.lo0;
            ent_lo1[wr.wr_idx]  <= wr.lo1;
            // global only when both halves say so
            ent_g[wr.wr_idx]    <= wr.lo0[`LO_G] & wr.lo1[`LO_G];
            ent_used[wr.wr_idx] <= 1'b1;
        end
    end

    // three associative compares in parallel
    for (genvar n = 0; n < `TLB_ENTRIES; n++) begin : g_match
        assign i_hit[n] = ent_used[n] && (ent_vpn2[n] == i_vpn2)
                          && (ent_g[n] || (ent_asid[n] == cur_asid));
        assign d_hit[n] = ent_used[n] && (ent_vpn2[n] == d_vpn2)
                          && (ent_g[n] || (ent_asid[n] == cur_asid));
        // probe uses the EntryHi asid, not the running one
        assign p_hit[n] = ent_used[n] && (ent_vpn2[n] == wr.vpn2)
                          && (ent_g[n] || (ent_asid[n] == wr.asid));
    end

    // and-or readout, hits are one-hot
    always_comb begin
        i_lo0 = '0;
        i_lo1 = '0;
        d_lo0 = '0;
        d_lo1 = '0;
        p_idx = '0;
        for (int n = 0; n < `TLB_ENTRIES; n++) begin
            i_lo0 |= ent_lo0[n] & {`ENTRY_LO_W{i_hit[n]}};
            i_lo1 |= ent_lo1[n] & {`ENTRY_LO_W{i_hit[n]}};
            d_lo0 |= ent_lo0[n] & {`ENTRY_LO_W{d_hit[n]}};
            d_lo1 |= ent_lo1[n] & {`ENTRY_LO_W{d_hit[n]}};
            p_idx |= p_hit[n] ? tlb_idx_t'(n) : '0;
        end
    end

    assign mt.i_found = |i_hit;
    assign mt.i_lo0   = i_lo0;
    assign mt.i_lo1   = i_lo1;
    assign mt.d_found = |d_hit;
    assign mt.d_lo0   = d_lo0;
    assign mt.d_lo1   = d_lo1;

    // probe result one edge after the decoder
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            mt.probe_strobe <= 1'b0;
            mt.probe_found  <= 1'b0;
            mt.probe_idx    <= '0;
        end else begin
            mt.probe_strobe <= (wr.op == op_probe);
            if (wr.op == op_probe) begin
                mt.probe_found <= |p_hit;
                mt.probe_idx   <= p_idx;
            end
        end
    end

    // software must never leave two entries answering the same lookup
    assert property (@(posedge aclk) disable iff (!rst_n)
        $onehot0(i_hit) && $onehot0(d_hit))
        else $error("tlb_entry_array: lookup matched more than one entry");

endmodule

`default_nettype wire

/* logic/tlb_cmd_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_cmd_decode (
    input  logic                   aclk,
    input  logic                   rst_n,
    input  logic                   tlbwi,
    input  logic                   tlbwr,
    input  logic                   tlbp,
    input  tlb_addr_pkg::tlb_idx_t index,
    input  tlb_addr_pkg::tlb_idx_t random_index,
    input  tlb_addr_pkg::vpn2_t    hi_vpn2,
    input  tlb_addr_pkg::asid_t    hi_asid,
    input  tlb_addr_pkg::entry_lo_t lo0,
    input  tlb_addr_pkg::entry_lo_t lo1,
    tlb_wr_if.src                  wr
);
    import tlb_op_pkg::*;

    tlb_op_e next_op;
    logic    any_cmd;

    assign any_cmd = tlbwi | tlbwr | tlbp;

    // strobes are exclusive, priority only keeps the mux simple
    always_comb begin
        if (tlbwi) begin
            next_op = op_wi;
        end else if (tlbwr) begin
            next_op = op_wr;
        end else if (tlbp) begin
            next_op = op_probe;
        end else begin
            next_op = op_none;
        end
    end

    // op lives for one cycle, back to op_none after
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wr.op <= op_none;
        end else begin
            wr.op <= next_op;
        end
    end

    // snapshot of the cp0 fields beside the op
    always_ff @(posedge aclk) begin
        if (any_cmd) begin
            wr.wr_idx <= tlbwr ? random_index : index;
            wr.vpn2   <= hi_vpn2;
            wr.asid   <= hi_asid;
            wr.lo0    <= lo0;
            wr.lo1    <= lo1;
        end
    end

    // cp0 side issues at most one maintenance op per cycle
    assert property (@(posedge aclk) disable iff (!rst_n)
        $onehot0({tlbwi, tlbwr, tlbp}))
        else $error("tlb_cmd_decode: more than one maintenance strobe high");

endmodule

`default_nettype wire

/* logic/tlb_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

// maintenance command from decoder to entry array
interface tlb_wr_if;
    import tlb_addr_pkg::*;
    import tlb_op_pkg::*;

    tlb_op_e   op;
    tlb_idx_t  wr_idx;
    vpn2_t     vpn2;
    asid_t     asid;
    entry_lo_t lo0;
    entry_lo_t lo1;

    modport src (output op, wr_idx, vpn2, asid, lo0, lo1);
    modport dst (input op, wr_idx, vpn2, asid, lo0, lo1);
endinterface

// match results from entry array to translator
interface tlb_match_if;
    import tlb_addr_pkg::*;

    logic      i_found;
    entry_lo_t i_lo0;
    entry_lo_t i_lo1;
    logic      d_found;
    entry_lo_t d_lo0;
    entry_lo_t d_lo1;
    // probe result, registered in the array
    logic      probe_found;
    tlb_idx_t  probe_idx;
    logic      probe_strobe;

    modport src (
        output i_found, i_lo0, i_lo1, d_found, d_lo0, d_lo1,
        output probe_found, probe_idx, probe_strobe
    );
    modport dst (
        input i_found, i_lo0, i_lo1, d_found, d_lo0, d_lo1,
        input probe_found, probe_idx, probe_strobe
    );
endinterface

`default_nettype wire

/* logic/tlb_op_pkg.sv */
`default_nettype none

package tlb_op_pkg;

    // maintenance command, held by the decoder for one cycle
    typedef enum logic [1:0] {
        op_none  = 2'd0,
        op_wi    = 2'd1,
        op_wr    = 2'd2,
        op_probe = 2'd3
    } tlb_op_e;

    // tlbwi and tlbwr differ only in where the index came from
    function automatic logic op_is_write(tlb_op_e op);
        return (op == op_wi) || (op == op_wr);
    endfunction

endpackage

`default_nettype wire

/* logic/tlb_addr_pkg.sv */
`default_nettype none

`include "tlb_macros.svh"

package tlb_addr_pkg;

    // byte addresses on both sides of the translation
    typedef logic [`ADDR_W-1:0] vaddr_t;
    typedef logic [`ADDR_W-1:0] paddr_t;

    // even/odd page pair shares one vpn2
    typedef logic [`VPN2_W-1:0] vpn2_t;

    typedef logic [`PFN_W-1:0] pfn_t;

    // address space id of the running process
    typedef logic [`ASID_W-1:0] asid_t;

    // entry number, also what a probe reports
    typedef logic [`TLB_IDX_W-1:0] tlb_idx_t;

    // pfn, c, d, v and g of one page
    typedef logic [`ENTRY_LO_W-1:0] entry_lo_t;

endpackage

`default_nettype wire

/* include/tlb_macros.svh */
`ifndef TLB_MACROS_SVH
`define TLB_MACROS_SVH

// tlb geometry
`define TLB_ENTRIES     16
`define TLB_IDX_W       4

// address and field widths
`define ADDR_W          32
`define VPN2_W          19
`define PFN_W           20
`define ASID_W          8
`define PAGE_OFS_W      12
`define ENTRY_LO_W      26
`define VPN2_LSB        (`PAGE_OFS_W + 1)

// one page in EntryLo layout, pfn on top
`define LO_PFN_MSB      25
`define LO_PFN_LSB      6
`define LO_C_MSB        5
`define LO_C_LSB        3
`define LO_D            2
`define LO_V            1
`define LO_G            0

// cache attribute for uncached pages
`define CACHE_UNCACHED  3'd2

`endif
